/* all.f */
+incdir+verification
src/databus_pkg.sv
src/burst_fifo.sv
src/burst_mem.sv
src/burst_master.sv
src/copy_top.sv
verification/tb_copy_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_copy_top -f all.f \
   -o tb_copy_top_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_copy_top_sim > sim.log 2>&1
cat sim.log

grep -q "All tests passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* src/burst_fifo.sv */
`timescale 1ns/1ps

module burst_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   output logic in_ready,
   input  T     in_data,
   output logic out_valid,
   input  logic out_ready,
   output T     out_data
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   T               buffer [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;

   logic push;
   logic pop;

   assign in_ready  = (count != (PTR_W+1)'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = buffer[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         buffer[wr_ptr] <= in_data;
      end
   end

endmodule

/* src/burst_master.sv */
`timescale 1ns/1ps

module burst_master (
   input  logic                           clk,
   input  logic                           rst,

   // Command queue
   input  logic                           cq_valid,
   output logic                           cq_ready,
   input  databus_pkg::cmd_t              cq_data,

   // Databus
   output logic                           bus_valid,
   input  logic                           bus_ready,
   output databus_pkg::addr_t             bus_addr,
   input  databus_pkg::data_t             bus_rdata,
   output databus_pkg::data_t             bus_wdata,
   output logic [databus_pkg::STRB_W-1:0] bus_wstrb,
   output databus_pkg::len_t              bus_len,
   input  logic                           bus_last,

   // Data FIFO
   output logic                           df_in_valid,
   input  logic                           df_in_ready,
   output databus_pkg::data_t             df_in_data,
   input  logic                           df_out_valid,
   output logic                           df_out_ready,
   input  databus_pkg::data_t             df_out_data,

   // Output stream
   output logic                           out_valid,
   input  logic                           out_ready,
   output databus_pkg::data_t             out_data,
   output logic                           out_last,

   output logic                           done
);
   import databus_pkg::*;

   typedef enum logic [2:0] {
      M_IDLE,
      M_RD_HDR,
      M_RD_BEAT,
      M_WR_HDR,
      M_WR_BEAT,
      M_FINISH
   } master_state_t;

   master_state_t state;

   // Current command
   cmd_op_t op;
   addr_t   src;
   addr_t   dst;
   len_t    blen;

   logic beat;

   assign beat = bus_valid && bus_ready;

   // *******************************************************************
   // Sequencing
   // *******************************************************************
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= M_IDLE;
      end else begin
         case (state)
            M_IDLE: begin
               if (cq_valid) begin
                  state <= M_RD_HDR;
               end
            end
            M_RD_HDR: begin
               if (bus_ready) begin
                  state <= M_RD_BEAT;
               end
            end
            M_RD_BEAT: begin
               if (beat && bus_last) begin
                  state <= (op == OP_COPY) ? M_WR_HDR : M_FINISH;
               end
            end
            M_WR_HDR: begin
               if (bus_ready) begin
                  state <= M_WR_BEAT;
               end
            end
            M_WR_BEAT: begin
               if (beat && bus_last) begin
                  state <= M_FINISH;
               end
            end
            M_FINISH: state <= M_IDLE;
            default:  state <= M_IDLE;
         endcase
      end
   end

   // Byte length minus one is (wlen + 1) * 4 - 1, i.e. wlen with the offset bits set
   always_ff @(posedge clk) begin
      if (cq_valid && cq_ready) begin
         op   <= cq_data.op;
         src  <= cq_data.src;
         dst  <= cq_data.dst;
         blen <= len_t'({cq_data.wlen, {OFFSET{1'b1}}});
      end
   end

   // *******************************************************************
   // Bus and stream steering
   // *******************************************************************
   always_comb begin
      cq_ready     = (state == M_IDLE);
      bus_valid    = 1'b0;
      bus_addr     = src;
      bus_wdata    = df_out_data;
      bus_wstrb    = '0;
      bus_len      = blen;
      df_in_valid  = 1'b0;
      df_in_data   = bus_rdata;
      df_out_ready = 1'b0;
      out_valid    = 1'b0;
      out_data     = bus_rdata;
      out_last     = 1'b0;
      done         = 1'b0;

      case (state)
         M_RD_HDR: begin
            bus_valid = 1'b1;
         end
         M_RD_BEAT: begin
            if (op == OP_COPY) begin
               bus_valid   = df_in_ready;
               df_in_valid = bus_ready;
            end else begin
               // Stall the memory while the stream is blocked
               bus_valid = out_ready;
               out_valid = bus_ready;
               out_last  = bus_last;
            end
         end
         M_WR_HDR: begin
            bus_valid = 1'b1;
            bus_addr  = dst;
            bus_wstrb = '1;
         end
         M_WR_BEAT: begin
            bus_valid    = df_out_valid;
            df_out_ready = bus_ready;
         end
         M_FINISH: begin
            done = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

/* src/burst_mem.sv */
`timescale 1ns/1ps

module burst_mem (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           bus_valid,
   output logic                           bus_ready,
   input  databus_pkg::addr_t             bus_addr,
   output databus_pkg::data_t             bus_rdata,
   input  databus_pkg::data_t             bus_wdata,
   input  logic [databus_pkg::STRB_W-1:0] bus_wstrb,
   input  databus_pkg::len_t              bus_len,
   output logic                           bus_last,
   input  logic                           insert_valid,
   input  databus_pkg::addr_t             insert_addr,
   input  databus_pkg::data_t             insert_data
);
   import databus_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE
   } mem_state_t;

   data_t      mem [MEM_WORDS];
   mem_state_t state;
   len_t       counter;
   addr_t      addr;
   logic       rd_valid;

   logic                     hdr;
   logic                     rd_beat;
   logic                     wr_beat;
   logic                     end_beat;
   logic                     fetch;
   logic [ADDR_W-OFFSET-1:0] word;

   assign word     = addr[ADDR_W-1:OFFSET];
   assign hdr      = (state == ST_IDLE) && bus_valid;
   assign rd_beat  = (state == ST_READ) && rd_valid && bus_valid;
   assign wr_beat  = (state == ST_WRITE) && bus_valid;
   assign end_beat = (rd_beat || wr_beat) && (counter == '0);

   // First word is fetched right after the header, later ones on each beat
   assign fetch = (state == ST_READ) && (!rd_valid || (rd_beat && counter != '0));

   assign bus_ready = (state == ST_IDLE) || (state == ST_READ && rd_valid) ||
                      (state == ST_WRITE);
   assign bus_last  = (state != ST_IDLE) && (counter == '0);

   // *******************************************************************
   // Burst control
   // *******************************************************************
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= ST_IDLE;
         counter  <= '0;
         addr     <= '0;
         rd_valid <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (hdr) begin
                  // Beats remaining minus one
                  counter <= bus_len >> OFFSET;
                  addr    <= bus_addr;
                  state   <= (bus_wstrb == '0) ? ST_READ : ST_WRITE;
               end
            end
            ST_READ: begin
               if (fetch) begin
                  rd_valid <= 1'b1;
                  addr     <= addr + addr_t'(STRB_W);
               end
               if (rd_beat) begin
                  counter <= counter - 1'b1;
               end
               if (end_beat) begin
                  rd_valid <= 1'b0;
                  state    <= ST_IDLE;
               end
            end
            ST_WRITE: begin
               if (wr_beat) begin
                  counter <= counter - 1'b1;
                  addr    <= addr + addr_t'(STRB_W);
               end
               if (end_beat) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Word array, backdoor insert goes in regardless of bus state
   always_ff @(posedge clk) begin
      if (wr_beat) begin
         mem[word] <= bus_wdata;
      end
      if (insert_valid) begin
         mem[insert_addr[ADDR_W-1:OFFSET]] <= insert_data;
      end
      if (fetch) begin
         bus_rdata <= mem[word];
      end
   end

endmodule

/* src/copy_top.sv */
`timescale 1ns/1ps

module copy_top (
   input  logic                           clk,
   input  logic                           rst,

   input  logic                           cmd_valid,
   output logic                           cmd_ready,
   input  databus_pkg::cmd_op_t           cmd_op,
   input  databus_pkg::addr_t             cmd_src,
   input  databus_pkg::addr_t             cmd_dst,
   input  logic [databus_pkg::WLEN_W-1:0] cmd_wlen,

   output logic                           done,

   output logic                           out_valid,
   input  logic                           out_ready,
   output databus_pkg::data_t             out_data,
   output logic                           out_last,

   input  logic                           insert_valid,
   input  databus_pkg::addr_t             insert_addr,
   input  databus_pkg::data_t             insert_data
);
   import databus_pkg::*;

   cmd_t cmd_in;
   logic cq_valid;
   logic cq_ready;
   cmd_t cq_data;

   logic               bus_valid;
   logic               bus_ready;
   addr_t              bus_addr;
   data_t              bus_rdata;
   data_t              bus_wdata;
   logic [STRB_W-1:0]  bus_wstrb;
   len_t               bus_len;
   logic               bus_last;

   logic  df_in_valid;
   logic  df_in_ready;
   data_t df_in_data;
   logic  df_out_valid;
   logic  df_out_ready;
   data_t df_out_data;

   assign cmd_in = '{op: cmd_op, src: cmd_src, dst: cmd_dst, wlen: cmd_wlen};

   burst_fifo #(.T(cmd_t), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
      .clk(clk), .rst(rst),
      .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_in),
      .out_valid(cq_valid), .out_ready(cq_ready), .out_data(cq_data)
   );

   // Holds a whole burst between the read and write phases of a copy
   burst_fifo #(.T(data_t), .DEPTH(BURST_WORDS)) u_data_fifo (
      .clk(clk), .rst(rst),
      .in_valid(df_in_valid), .in_ready(df_in_ready), .in_data(df_in_data),
      .out_valid(df_out_valid), .out_ready(df_out_ready), .out_data(df_out_data)
   );

   burst_master u_master (
      .clk(clk), .rst(rst),
      .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_data(cq_data),
      .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_addr(bus_addr),
      .bus_rdata(bus_rdata), .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb),
      .bus_len(bus_len), .bus_last(bus_last),
      .df_in_valid(df_in_valid), .df_in_ready(df_in_ready), .df_in_data(df_in_data),
      .df_out_valid(df_out_valid), .df_out_ready(df_out_ready), .df_out_data(df_out_data),
      .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
      .out_last(out_last), .done(done)
   );

   burst_mem u_mem (
      .clk(clk), .rst(rst),
      .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_addr(bus_addr),
      .bus_rdata(bus_rdata), .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb),
      .bus_len(bus_len), .bus_last(bus_last),
      .insert_valid(insert_valid), .insert_addr(insert_addr), .insert_data(insert_data)
   );

endmodule

/* src/databus_pkg.sv */
package databus_pkg;

   // Databus geometry
   localparam int ADDR_W = 10;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int OFFSET = 2;
   localparam int LEN_W  = 8;

   localparam int MEM_WORDS   = 2 ** (ADDR_W - OFFSET);
   localparam int BURST_WORDS = 16;
   localparam int CMD_DEPTH   = 4;

   // Command length is word count minus one
   localparam int WLEN_W = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [LEN_W-1:0]  len_t;

   typedef enum logic {
      OP_COPY,
      OP_DUMP
   } cmd_op_t;

   typedef struct packed {
      cmd_op_t           op;
      addr_t             src;
      addr_t             dst;
      logic [WLEN_W-1:0] wlen;
   } cmd_t;

endpackage

/* verification/tb_checks.svh */
// *********************************************************************
// Compare tasks
// *********************************************************************
task automatic check_data(input string name, input data_t got, input data_t exp);
   if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
   end
endtask

task automatic check_last(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
   end
endtask

task automatic check_done_count(input string name, input integer got, input integer exp);
   if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
   end
endtask

// *********************************************************************
// Output collection
// *********************************************************************
task automatic clear_output();
   got_data.delete();
   got_last.delete();
   exp_data.delete();
   exp_last.delete();
endtask

// Collected stream against the model's words, then start afresh
task automatic compare_output(input string tag);
   int n;
   int i;
   if (got_data.size() != exp_data.size()) begin
      $display("%s: received %0d output words but expected %0d", tag, got_data.size(),
               exp_data.size());
      errors++;
   end
   n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
   for (i = 0; i < n; i++) begin
      check_data($sformatf("%s out_data[%0d]", tag, i), got_data[i], exp_data[i]);
      check_last($sformatf("%s out_last[%0d]", tag, i), got_last[i], exp_last[i]);
   end
   clear_output();
endtask

/* verification/tb_copy_top.sv */
`timescale 1ns/1ps

module tb_copy_top;
   import databus_pkg::*;

   // Roughly 1500 cycles of tests plus a wide margin
   localparam int MAX_CYCLES = 20000;

   logic              clk;
   logic              rst;
   logic              cmd_valid;
   logic              cmd_ready;
   cmd_op_t           cmd_op;
   addr_t             cmd_src;
   addr_t             cmd_dst;
   logic [WLEN_W-1:0] cmd_wlen;
   logic              done;
   logic              out_valid;
   logic              out_ready;
   data_t             out_data;
   logic              out_last;
   logic              insert_valid;
   addr_t             insert_addr;
   data_t             insert_data;

   data_t model [MEM_WORDS];
   data_t got_data [$];
   logic  got_last [$];
   data_t exp_data [$];
   logic  exp_last [$];

   int errors;
   int errors_at_start;
   int tests_run;
   int tests_failed;
   int done_count;
   int cmds_issued;
   int cycles;
   bit stall_mode;

   `include "tb_checks.svh"

   copy_top UUT (
      .clk(clk), .rst(rst),
      .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
      .cmd_src(cmd_src), .cmd_dst(cmd_dst), .cmd_wlen(cmd_wlen),
      .done(done),
      .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
      .out_last(out_last),
      .insert_valid(insert_valid), .insert_addr(insert_addr), .insert_data(insert_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run stopped after %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   // Output sink and done counter on the falling edge
   initial begin
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         out_ready = stall_mode ? 1'($urandom_range(0, 1)) : 1'b1;
         if (out_valid && out_ready) begin
            got_data.push_back(out_data);
            got_last.push_back(out_last);
         end
         if (done) begin
            done_count++;
         end
      end
   end

   // *******************************************************************
   // Stimulus helpers
   // *******************************************************************
   task automatic insert_word(input int w, input data_t d);
      insert_valid = 1'b1;
      insert_addr  = addr_t'(w << OFFSET);
      insert_data  = d;
      @(negedge clk);
      insert_valid = 1'b0;
      model[w] = d;
   endtask

   // Queue one command and apply it to the model in issue order
   task automatic issue_cmd(input cmd_op_t op, input int src_w, input int dst_w,
                            input int wlen, output bit first_try);
      data_t words [$];
      int    i;
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_src   = addr_t'(src_w << OFFSET);
      cmd_dst   = addr_t'(dst_w << OFFSET);
      cmd_wlen  = WLEN_W'(wlen);
      first_try = cmd_ready;
      while (!cmd_ready) begin
         @(negedge clk);
      end
      @(negedge clk);
      cmd_valid = 1'b0;
      cmds_issued++;
      // Whole burst is read before any word is written
      for (i = 0; i <= wlen; i++) begin
         words.push_back(model[(src_w + i) % MEM_WORDS]);
      end
      for (i = 0; i <= wlen; i++) begin
         if (op == OP_COPY) begin
            model[(dst_w + i) % MEM_WORDS] = words[i];
         end else begin
            exp_data.push_back(words[i]);
            exp_last.push_back(i == wlen);
         end
      end
   endtask

   task automatic wait_all_done();
      while (done_count < cmds_issued) begin
         @(negedge clk);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("Test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
                  errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   // *******************************************************************
   // Tests
   // *******************************************************************
   initial begin
      int      k;
      int      i;
      int      src_w;
      int      dst_w;
      int      wlen;
      int      base;
      bit      first_try;
      data_t   ref_q [$];
      cmd_op_t c_op [4];
      int      c_src [4];
      int      c_dst [4];
      int      c_wlen [4];

      void'($urandom(32'hbf264046));
      rst          = 1'b1;
      cmd_valid    = 1'b0;
      cmd_op       = OP_COPY;
      cmd_src      = '0;
      cmd_dst      = '0;
      cmd_wlen     = '0;
      insert_valid = 1'b0;
      insert_addr  = '0;
      insert_data  = '0;
      stall_mode   = 1'b0;
      errors = 0;
      errors_at_start = 0;
      tests_run = 0;
      tests_failed = 0;
      done_count = 0;
      cmds_issued = 0;
      for (k = 0; k < MEM_WORDS; k++) begin
         model[k] = '0;
      end

      repeat (16) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      check_last("out_valid", out_valid, 1'b0);
      check_last("done", done, 1'b0);
      check_last("cmd_ready", cmd_ready, 1'b1);
      end_test("reset state");

      for (k = 0; k < MEM_WORDS; k++) begin
         insert_word(k, $urandom());
      end
      for (k = 0; k < 6; k++) begin
         issue_cmd(OP_DUMP, $urandom_range(0, MEM_WORDS - 1), 0,
                   $urandom_range(0, BURST_WORDS - 1), first_try);
         wait_all_done();
         compare_output("preload dump");
      end
      end_test("dump of preloaded words");

      for (k = 0; k < 6; k++) begin
         src_w = $urandom_range(0, MEM_WORDS - 1);
         dst_w = $urandom_range(0, MEM_WORDS - 1);
         wlen  = $urandom_range(0, BURST_WORDS - 1);
         ref_q.delete();
         for (i = 0; i <= wlen; i++) begin
            ref_q.push_back(model[(src_w + i) % MEM_WORDS]);
         end
         issue_cmd(OP_COPY, src_w, dst_w, wlen, first_try);
         wait_all_done();
         issue_cmd(OP_DUMP, dst_w, 0, wlen, first_try);
         wait_all_done();
         for (i = 0; i < got_data.size() && i < ref_q.size(); i++) begin
            check_data($sformatf("copied word %0d", i), got_data[i], ref_q[i]);
         end
         compare_output("copy destination");
         // Neighbours of the destination range
         issue_cmd(OP_DUMP, (dst_w + MEM_WORDS - 1) % MEM_WORDS, 0, 0, first_try);
         wait_all_done();
         compare_output("word below");
         issue_cmd(OP_DUMP, (dst_w + wlen + 1) % MEM_WORDS, 0, 0, first_try);
         wait_all_done();
         compare_output("word above");
      end
      end_test("random copy");

      for (k = 0; k < 4; k++) begin
         src_w = $urandom_range(0, MEM_WORDS - 1);
         wlen  = $urandom_range(0, BURST_WORDS - 1);
         ref_q.delete();
         for (i = 0; i <= wlen; i++) begin
            ref_q.push_back(model[(src_w + i) % MEM_WORDS]);
         end
         issue_cmd(OP_DUMP, src_w, 0, wlen, first_try);
         wait_all_done();
         compare_output("dump held");
         stall_mode = 1'b1;
         issue_cmd(OP_DUMP, src_w, 0, wlen, first_try);
         wait_all_done();
         stall_mode = 1'b0;
         for (i = 0; i < got_data.size() && i < ref_q.size(); i++) begin
            check_data($sformatf("stalled word %0d", i), got_data[i], ref_q[i]);
         end
         compare_output("dump stalled");
      end
      end_test("dump with back-pressure");

      // First copy overlaps its own source
      c_src[0]  = $urandom_range(0, MEM_WORDS - 1);
      c_dst[0]  = (c_src[0] + $urandom_range(1, 8)) % MEM_WORDS;
      c_wlen[0] = $urandom_range(0, BURST_WORDS - 1);
      c_src[1]  = $urandom_range(0, MEM_WORDS - 1);
      c_dst[1]  = $urandom_range(0, MEM_WORDS - 1);
      c_wlen[1] = $urandom_range(0, BURST_WORDS - 1);
      c_op[0] = OP_COPY;
      c_op[1] = OP_COPY;
      c_op[2] = OP_DUMP;
      c_op[3] = OP_DUMP;
      for (k = 2; k < 4; k++) begin
         c_src[k]  = c_dst[k - 2];
         c_dst[k]  = 0;
         c_wlen[k] = c_wlen[k - 2];
      end
      base = done_count;
      for (k = 0; k < 4; k++) begin
         issue_cmd(c_op[k], c_src[k], c_dst[k], c_wlen[k], first_try);
         if (!first_try) begin
            $display("Command %0d was held off although the command FIFO had room", k);
            errors++;
         end
      end
      wait_all_done();
      check_done_count("done pulses", done_count - base, 4);
      compare_output("back to back");
      end_test("back to back commands");

      $display("Summary: %0d tests run, %0d failed, %0d check errors", tests_run,
               tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
